/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // widths that carry a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;
    typedef logic [1:0]  mem_size_t;

    // access size codes
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // memory geometry, base maps to word 0
    localparam int    MEM_WORDS = 1024;
    localparam int    IDX_W     = $clog2(MEM_WORDS);
    localparam addr_t MEM_BASE  = 32'h8000_0000;

    // cycles from address accept to rvalid
    localparam int SRAM_LATENCY = 4;
    localparam int LAT_CNT_W    = $clog2(SRAM_LATENCY + 1);

    // read port owner
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_LSU
    } arb_state_t;

    // load/store unit progress
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_ADDR,
        LSU_DATA
    } lsu_state_t;

endpackage

`default_nettype wire

/* sram_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_slave (
    input  wire               clk,
    input  wire               rst,
    // read address channel
    input  mem_pkg::addr_t    araddr,
    input  wire               arvalid,
    output logic              arready,
    // read data channel
    output mem_pkg::word_t    rdata,
    output logic              rvalid,
    input  wire               rready,
    // write strobe
    input  wire               w_en,
    input  mem_pkg::addr_t    waddr,
    input  mem_pkg::word_t    wdata,
    input  mem_pkg::wmask_t   wmask
);
    import mem_pkg::*;

    word_t mem [MEM_WORDS];

    // read data held from accept to handshake
    word_t hold_q;
    logic [LAT_CNT_W-1:0] cnt_q;

    addr_t roff;
    addr_t woff;
    logic [IDX_W-1:0] ridx;
    logic [IDX_W-1:0] widx;

    logic ar_hs;
    logic r_hs;

    // offset from base, then word index bits only
    assign roff = araddr - MEM_BASE;
    assign woff = waddr - MEM_BASE;
    assign ridx = roff[IDX_W+1:2];
    assign widx = woff[IDX_W+1:2];

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    assign rdata = hold_q;

    // array and capture, old word wins on a same-cycle write
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            hold_q <= mem[ridx];
        end
        if (w_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    mem[widx][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // accept, latency countdown, data handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            if (ar_hs) begin
                arready <= 1'b0;
                cnt_q   <= LAT_CNT_W'(SRAM_LATENCY);
            end else if (cnt_q > 1) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (cnt_q == 1) begin
                // last tick, data goes valid
                cnt_q  <= '0;
                rvalid <= 1'b1;
            end else if (r_hs) begin
                // taken, port free next cycle
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  wire               clk,
    input  wire               rst,
    // fetch peer
    input  mem_pkg::addr_t    f_araddr,
    input  wire               f_arvalid,
    output logic              f_arready,
    output mem_pkg::word_t    f_rdata,
    output logic              f_rvalid,
    input  wire               f_rready,
    // lsu peer
    input  mem_pkg::addr_t    l_araddr,
    input  wire               l_arvalid,
    output logic              l_arready,
    output mem_pkg::word_t    l_rdata,
    output logic              l_rvalid,
    input  wire               l_rready,
    // sram read port
    output mem_pkg::addr_t    araddr,
    output logic              arvalid,
    input  wire               arready,
    input  mem_pkg::word_t    rdata,
    input  wire               rvalid,
    output logic              rready
);
    import mem_pkg::*;

    arb_state_t state_q;
    arb_state_t pick;
    arb_state_t grant;

    // last grant went to the lsu
    logic last_lsu_q;

    // choice while idle alternates on a tie
    always_comb begin
        if (f_arvalid && l_arvalid) begin
            pick = last_lsu_q ? ARB_FETCH : ARB_LSU;
        end else if (f_arvalid) begin
            pick = ARB_FETCH;
        end else if (l_arvalid) begin
            pick = ARB_LSU;
        end else begin
            pick = ARB_IDLE;
        end
    end

    // owner decided in the same cycle as the request
    assign grant = (state_q == ARB_IDLE) ? pick : state_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ARB_IDLE;
            last_lsu_q <= 1'b0;
        end else if (state_q == ARB_IDLE) begin
            state_q <= pick;
            if (pick != ARB_IDLE) begin
                last_lsu_q <= (pick == ARB_LSU);
            end
        end else if (rvalid && rready) begin
            // release on the data handshake
            state_q <= ARB_IDLE;
        end
    end

    // toward the sram
    assign araddr  = (grant == ARB_LSU) ? l_araddr : f_araddr;
    assign arvalid = ((grant == ARB_FETCH) && f_arvalid) || ((grant == ARB_LSU) && l_arvalid);
    assign rready  = ((grant == ARB_FETCH) && f_rready) || ((grant == ARB_LSU) && l_rready);

    // back to the owner only
    assign f_arready = (grant == ARB_FETCH) && arready;
    assign l_arready = (grant == ARB_LSU) && arready;
    assign f_rvalid  = (grant == ARB_FETCH) && rvalid;
    assign l_rvalid  = (grant == ARB_LSU) && rvalid;
    assign f_rdata   = rdata;
    assign l_rdata   = rdata;

endmodule

`default_nettype wire

/* ifu_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module ifu_fetch (
    input  wire               clk,
    input  wire               rst,
    input  wire               fetch_start,
    input  mem_pkg::addr_t    start_pc,
    input  wire               fetch_next,
    output mem_pkg::word_t    inst,
    output logic              inst_valid,
    output mem_pkg::addr_t    pc,
    // read port
    output mem_pkg::addr_t    f_araddr,
    output logic              f_arvalid,
    input  wire               f_arready,
    input  mem_pkg::word_t    f_rdata,
    input  wire               f_rvalid,
    output logic              f_rready
);
    import mem_pkg::*;

    addr_t pc_q;
    logic  busy_q;
    logic  arvalid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= MEM_BASE;
            busy_q    <= 1'b0;
            arvalid_q <= 1'b0;
        end else if (!busy_q) begin
            // new pulses only while idle, start wins
            if (fetch_start) begin
                pc_q      <= start_pc;
                busy_q    <= 1'b1;
                arvalid_q <= 1'b1;
            end else if (fetch_next) begin
                pc_q      <= pc_q + 32'd4;
                busy_q    <= 1'b1;
                arvalid_q <= 1'b1;
            end
        end else begin
            if (f_arvalid && f_arready) begin
                arvalid_q <= 1'b0;
            end
            if (f_rvalid && f_rready) begin
                busy_q <= 1'b0;
            end
        end
    end

    // address held stable until accepted
    assign f_araddr  = pc_q;
    assign f_arvalid = arvalid_q;
    assign f_rready  = busy_q;

    // instruction reported with its own address
    assign inst       = f_rdata;
    assign pc         = pc_q;
    assign inst_valid = f_rvalid && f_rready;

endmodule

`default_nettype wire

/* lsu_access.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_access (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 mem_req,
    input  wire                 mem_we,
    input  mem_pkg::addr_t      mem_addr,
    input  mem_pkg::mem_size_t  mem_size,
    input  wire                 mem_unsigned,
    input  mem_pkg::word_t      mem_wdata,
    output mem_pkg::word_t      load_data,
    output logic                mem_done,
    // read port
    output mem_pkg::addr_t      l_araddr,
    output logic                l_arvalid,
    input  wire                 l_arready,
    input  mem_pkg::word_t      l_rdata,
    input  wire                 l_rvalid,
    output logic                l_rready,
    // write strobe
    output logic                w_en,
    output mem_pkg::addr_t      waddr,
    output mem_pkg::word_t      wdata,
    output mem_pkg::wmask_t     wmask
);
    import mem_pkg::*;

    lsu_state_t state_q;

    // latched load request
    addr_t     addr_q;
    mem_size_t size_q;
    logic      uns_q;

    word_t shifted;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LSU_IDLE;
            w_en    <= 1'b0;
        end else begin
            w_en <= 1'b0;
            case (state_q)
                LSU_IDLE: begin
                    if (mem_req && mem_we) begin
                        w_en <= 1'b1;
                    end else if (mem_req) begin
                        state_q <= LSU_ADDR;
                    end
                end
                LSU_ADDR: if (l_arready) state_q <= LSU_DATA;
                LSU_DATA: if (l_rvalid) state_q <= LSU_IDLE;
                default:  state_q <= LSU_IDLE;
            endcase
        end
    end

    // request payload captured on accept
    always_ff @(posedge clk) begin
        if (state_q == LSU_IDLE && mem_req) begin
            addr_q <= mem_addr;
            size_q <= mem_size;
            uns_q  <= mem_unsigned;
            waddr  <= mem_addr;
            // data copied into every lane and the mask picks the ones written
            case (mem_size)
                SIZE_BYTE: begin
                    wmask <= 4'b0001 << mem_addr[1:0];
                    wdata <= {4{mem_wdata[7:0]}};
                end
                SIZE_HALF: begin
                    wmask <= mem_addr[1] ? 4'b1100 : 4'b0011;
                    wdata <= {2{mem_wdata[15:0]}};
                end
                default: begin
                    wmask <= 4'b1111;
                    wdata <= mem_wdata;
                end
            endcase
        end
    end

    assign l_araddr  = {addr_q[31:2], 2'b00};
    assign l_arvalid = (state_q == LSU_ADDR);
    assign l_rready  = (state_q == LSU_DATA);

    // store done with its strobe and load done on the data handshake
    assign mem_done = w_en || (l_rvalid && l_rready);

    // selected lane down to bit 0
    assign shifted = l_rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: load_data = uns_q ? {24'b0, shifted[7:0]}
                                         : {{24{shifted[7]}}, shifted[7:0]};
            SIZE_HALF: load_data = uns_q ? {16'b0, shifted[15:0]}
                                         : {{16{shifted[15]}}, shifted[15:0]};
            default:   load_data = l_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* mem_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top (
    input  wire                 clk,
    input  wire                 rst,
    // fetch side
    input  wire                 fetch_start,
    input  mem_pkg::addr_t      start_pc,
    input  wire                 fetch_next,
    output mem_pkg::word_t      inst,
    output logic                inst_valid,
    output mem_pkg::addr_t      pc,
    // load/store side
    input  wire                 mem_req,
    input  wire                 mem_we,
    input  mem_pkg::addr_t      mem_addr,
    input  mem_pkg::mem_size_t  mem_size,
    input  wire                 mem_unsigned,
    input  mem_pkg::word_t      mem_wdata,
    output mem_pkg::word_t      load_data,
    output logic                mem_done
);
    import mem_pkg::*;

    // fetch to arbiter
    addr_t f_araddr;
    logic  f_arvalid;
    logic  f_arready;
    word_t f_rdata;
    logic  f_rvalid;
    logic  f_rready;

    // lsu to arbiter
    addr_t l_araddr;
    logic  l_arvalid;
    logic  l_arready;
    word_t l_rdata;
    logic  l_rvalid;
    logic  l_rready;

    // arbiter to sram
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    word_t rdata;
    logic  rvalid;
    logic  rready;

    // write strobe bypasses the arbiter
    logic   w_en;
    addr_t  waddr;
    word_t  wdata;
    wmask_t wmask;

    ifu_fetch ifu_i (
        .clk(clk), .rst(rst),
        .fetch_start(fetch_start), .start_pc(start_pc), .fetch_next(fetch_next),
        .inst(inst), .inst_valid(inst_valid), .pc(pc),
        .f_araddr(f_araddr), .f_arvalid(f_arvalid), .f_arready(f_arready),
        .f_rdata(f_rdata), .f_rvalid(f_rvalid), .f_rready(f_rready)
    );

    lsu_access lsu_i (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_unsigned(mem_unsigned), .mem_wdata(mem_wdata),
        .load_data(load_data), .mem_done(mem_done),
        .l_araddr(l_araddr), .l_arvalid(l_arvalid), .l_arready(l_arready),
        .l_rdata(l_rdata), .l_rvalid(l_rvalid), .l_rready(l_rready),
        .w_en(w_en), .waddr(waddr), .wdata(wdata), .wmask(wmask)
    );

    mem_arbiter arb_i (
        .clk(clk), .rst(rst),
        .f_araddr(f_araddr), .f_arvalid(f_arvalid), .f_arready(f_arready),
        .f_rdata(f_rdata), .f_rvalid(f_rvalid), .f_rready(f_rready),
        .l_araddr(l_araddr), .l_arvalid(l_arvalid), .l_arready(l_arready),
        .l_rdata(l_rdata), .l_rvalid(l_rvalid), .l_rready(l_rready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready)
    );

    sram_slave sram_i (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .w_en(w_en), .waddr(waddr), .wdata(wdata), .wmask(wmask)
    );

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    // row operations
    localparam int OP_STORE  = 0;
    localparam int OP_LOAD   = 1;
    localparam int OP_FSTART = 2;
    localparam int OP_FNEXT  = 3;
    localparam int OP_BOTH   = 4;

    localparam int    MAX_ROWS   = 64;
    localparam int    ROW_WAIT   = 30;
    localparam int    ROW_CYCLES = 40;
    localparam addr_t DATA_BASE  = MEM_BASE + 32'h100;
    localparam addr_t FETCH_BASE = MEM_BASE + 32'h40;

    logic      clk = 1'b0;
    logic      rst;
    logic      fetch_start;
    addr_t     start_pc;
    logic      fetch_next;
    word_t     inst;
    logic      inst_valid;
    addr_t     pc;
    logic      mem_req;
    logic      mem_we;
    addr_t     mem_addr;
    mem_size_t mem_size;
    logic      mem_unsigned;
    word_t     mem_wdata;
    word_t     load_data;
    logic      mem_done;

    // stimulus and expected values per row
    int        row_op       [MAX_ROWS];
    addr_t     row_addr     [MAX_ROWS];
    mem_size_t row_size     [MAX_ROWS];
    logic      row_uns      [MAX_ROWS];
    word_t     row_wdata    [MAX_ROWS];
    addr_t     row_faddr    [MAX_ROWS];
    word_t     row_exp_load [MAX_ROWS];
    word_t     row_exp_inst [MAX_ROWS];
    addr_t     row_exp_pc   [MAX_ROWS];
    int        num_rows = 0;

    // reference memory and fetch pointer
    word_t model_mem [MEM_WORDS];
    addr_t fetch_pc_model;
    word_t rand_state = 32'hfd3e_1134;

    int err_cnt     = 0;
    int check_cnt   = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    mem_subsys_top dut_i (
        .clk(clk), .rst(rst),
        .fetch_start(fetch_start), .start_pc(start_pc), .fetch_next(fetch_next),
        .inst(inst), .inst_valid(inst_valid), .pc(pc),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_unsigned(mem_unsigned), .mem_wdata(mem_wdata),
        .load_data(load_data), .mem_done(mem_done)
    );

    always #5 clk = ~clk;

    // hard stop sized from the table length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    function automatic word_t next_rand(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_data(output word_t d);
        rand_state = next_rand(rand_state);
        d = rand_state;
    endtask

    function automatic int word_index(input addr_t a);
        addr_t off;
        off = a - MEM_BASE;
        return int'(off[IDX_W+1:2]);
    endfunction

    // byte-lane rule for stores
    task automatic model_store(input addr_t a, input mem_size_t sz, input word_t d);
        int idx;
        idx = word_index(a);
        case (sz)
            SIZE_BYTE: model_mem[idx][int'(a[1:0])*8 +: 8] = d[7:0];
            SIZE_HALF: model_mem[idx][int'(a[1])*16 +: 16] = d[15:0];
            default:   model_mem[idx] = d;
        endcase
    endtask

    function automatic word_t model_load(input addr_t a, input mem_size_t sz, input logic uns);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[word_index(a)];
        b = w[int'(a[1:0])*8 +: 8];
        h = w[int'(a[1])*16 +: 16];
        case (sz)
            SIZE_BYTE: return uns ? {24'b0, b} : {{24{b[7]}}, b};
            SIZE_HALF: return uns ? {16'b0, h} : {{16{h[15]}}, h};
            default:   return w;
        endcase
    endfunction

    // expected values worked out as the row is added
    task automatic add_row(input int op, input addr_t a, input mem_size_t sz,
                           input logic uns, input word_t d, input addr_t fa);
        row_op[num_rows]       = op;
        row_addr[num_rows]     = a;
        row_size[num_rows]     = sz;
        row_uns[num_rows]      = uns;
        row_wdata[num_rows]    = d;
        row_faddr[num_rows]    = fa;
        row_exp_load[num_rows] = '0;
        row_exp_inst[num_rows] = '0;
        row_exp_pc[num_rows]   = '0;
        if (op == OP_STORE) begin
            model_store(a, sz, d);
        end
        if (op == OP_LOAD || op == OP_BOTH) begin
            row_exp_load[num_rows] = model_load(a, sz, uns);
        end
        if (op == OP_FSTART || op == OP_BOTH) begin
            fetch_pc_model = fa;
        end else if (op == OP_FNEXT) begin
            fetch_pc_model = fetch_pc_model + 32'd4;
        end
        if (op == OP_FSTART || op == OP_FNEXT || op == OP_BOTH) begin
            row_exp_pc[num_rows]   = fetch_pc_model;
            row_exp_inst[num_rows] = model_load(fetch_pc_model, SIZE_WORD, 1'b0);
        end
        num_rows++;
    endtask

    task automatic build_table();
        int    i;
        word_t d;
        // full words first so every later load reads written bytes
        for (i = 0; i < 8; i++) begin
            draw_data(d);
            d[31] = i[0];
            add_row(OP_STORE, DATA_BASE + addr_t'(4 * i), SIZE_WORD, 1'b0, d, '0);
        end
        add_row(OP_LOAD, DATA_BASE, SIZE_WORD, 1'b0, '0, '0);
        add_row(OP_LOAD, DATA_BASE + 32'd4, SIZE_WORD, 1'b0, '0, '0);
        // one byte per lane then both halves
        for (i = 0; i < 4; i++) begin
            draw_data(d);
            d[7] = !i[0];
            add_row(OP_STORE, DATA_BASE + addr_t'(i), SIZE_BYTE, 1'b0, d, '0);
        end
        draw_data(d);
        d[15] = 1'b1;
        add_row(OP_STORE, DATA_BASE + 32'd4, SIZE_HALF, 1'b0, d, '0);
        draw_data(d);
        d[15] = 1'b0;
        add_row(OP_STORE, DATA_BASE + 32'd6, SIZE_HALF, 1'b0, d, '0);
        add_row(OP_LOAD, DATA_BASE, SIZE_WORD, 1'b0, '0, '0);
        add_row(OP_LOAD, DATA_BASE + 32'd4, SIZE_WORD, 1'b0, '0, '0);
        // sign and zero extension
        for (i = 0; i < 4; i++) begin
            add_row(OP_LOAD, DATA_BASE + addr_t'(i), SIZE_BYTE, 1'b0, '0, '0);
            add_row(OP_LOAD, DATA_BASE + addr_t'(i), SIZE_BYTE, 1'b1, '0, '0);
        end
        for (i = 0; i < 2; i++) begin
            add_row(OP_LOAD, DATA_BASE + addr_t'(4 + 2 * i), SIZE_HALF, 1'b0, '0, '0);
            add_row(OP_LOAD, DATA_BASE + addr_t'(4 + 2 * i), SIZE_HALF, 1'b1, '0, '0);
        end
        // instructions then a four-word fetch run
        for (i = 0; i < 4; i++) begin
            draw_data(d);
            add_row(OP_STORE, FETCH_BASE + addr_t'(4 * i), SIZE_WORD, 1'b0, d, '0);
        end
        add_row(OP_FSTART, '0, SIZE_WORD, 1'b0, '0, FETCH_BASE);
        for (i = 0; i < 3; i++) begin
            add_row(OP_FNEXT, '0, SIZE_WORD, 1'b0, '0, '0);
        end
        // ties with single requests between them to swap the round-robin order
        add_row(OP_BOTH, DATA_BASE + 32'h08, SIZE_WORD, 1'b0, '0, FETCH_BASE);
        add_row(OP_LOAD, DATA_BASE + 32'h0d, SIZE_BYTE, 1'b0, '0, '0);
        add_row(OP_BOTH, DATA_BASE + 32'h12, SIZE_HALF, 1'b1, '0, FETCH_BASE + 32'h4);
        add_row(OP_FSTART, '0, SIZE_WORD, 1'b0, '0, FETCH_BASE + 32'h8);
        add_row(OP_BOTH, DATA_BASE + 32'h17, SIZE_BYTE, 1'b0, '0, FETCH_BASE + 32'hc);
        add_row(OP_LOAD, DATA_BASE + 32'h18, SIZE_WORD, 1'b0, '0, '0);
        add_row(OP_BOTH, DATA_BASE + 32'h1c, SIZE_WORD, 1'b0, '0, FETCH_BASE);
        // loads right behind each other, every one naturally aligned
        for (i = 0; i < 8; i++) begin
            add_row(OP_LOAD, DATA_BASE + addr_t'(4 * i + (i % 4)),
                    i[0] ? SIZE_BYTE : (i[1] ? SIZE_HALF : SIZE_WORD), i[1], '0, '0);
        end
    endtask

    task automatic check_load(input int r);
        check_cnt++;
        if (load_data !== row_exp_load[r]) begin
            $display("error at %0t ns: row %0d load_data %h, expected %h",
                     $time, r, load_data, row_exp_load[r]);
            err_cnt++;
        end
    endtask

    task automatic check_inst(input int r);
        check_cnt++;
        if (inst !== row_exp_inst[r]) begin
            $display("error at %0t ns: row %0d inst %h, expected %h",
                     $time, r, inst, row_exp_inst[r]);
            err_cnt++;
        end
        if (pc !== row_exp_pc[r]) begin
            $display("error at %0t ns: row %0d pc %h, expected %h",
                     $time, r, pc, row_exp_pc[r]);
            err_cnt++;
        end
    endtask

    task automatic run_row(input int r);
        logic want_lsu;
        logic want_inst;
        logic got_lsu;
        logic got_inst;
        int   waited;
        want_lsu  = (row_op[r] == OP_STORE) || (row_op[r] == OP_LOAD) || (row_op[r] == OP_BOTH);
        want_inst = (row_op[r] == OP_FSTART) || (row_op[r] == OP_FNEXT) || (row_op[r] == OP_BOTH);
        got_lsu   = 1'b0;
        got_inst  = 1'b0;
        waited    = 0;
        @(posedge clk);
        mem_req      <= want_lsu;
        mem_we       <= (row_op[r] == OP_STORE);
        mem_addr     <= row_addr[r];
        mem_size     <= row_size[r];
        mem_unsigned <= row_uns[r];
        mem_wdata    <= row_wdata[r];
        fetch_start  <= (row_op[r] == OP_FSTART) || (row_op[r] == OP_BOTH);
        start_pc     <= row_faddr[r];
        fetch_next   <= (row_op[r] == OP_FNEXT);
        @(posedge clk);
        // single-cycle pulses
        mem_req     <= 1'b0;
        fetch_start <= 1'b0;
        fetch_next  <= 1'b0;
        while (((want_lsu && !got_lsu) || (want_inst && !got_inst)) && waited < ROW_WAIT) begin
            // outputs settled mid-cycle
            @(negedge clk);
            waited++;
            if (mem_done) begin
                if (!want_lsu || got_lsu) begin
                    $display("error at %0t ns: row %0d unexpected mem_done", $time, r);
                    err_cnt++;
                end else begin
                    got_lsu = 1'b1;
                    if (row_op[r] != OP_STORE) begin
                        check_load(r);
                    end
                end
            end
            if (inst_valid) begin
                if (!want_inst || got_inst) begin
                    $display("error at %0t ns: row %0d unexpected inst_valid", $time, r);
                    err_cnt++;
                end else begin
                    got_inst = 1'b1;
                    check_inst(r);
                end
            end
        end
        if ((want_lsu && !got_lsu) || (want_inst && !got_inst)) begin
            $display("row %0d did not complete: no mem_done or inst_valid within %0d cycles",
                     r, ROW_WAIT);
            err_cnt++;
        end
    endtask

    initial begin
        int r;
        rst          <= 1'b1;
        fetch_start  <= 1'b0;
        start_pc     <= '0;
        fetch_next   <= 1'b0;
        mem_req      <= 1'b0;
        mem_we       <= 1'b0;
        mem_addr     <= '0;
        mem_size     <= SIZE_WORD;
        mem_unsigned <= 1'b0;
        mem_wdata    <= '0;
        fetch_pc_model = MEM_BASE;
        build_table();
        cycle_limit = num_rows * ROW_CYCLES + 10;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (2) @(posedge clk);
        $display("rows: %0d, checks: %0d, errors: %0d", num_rows, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
mem_pkg.sv
sram_slave.sv
mem_arbiter.sv
ifu_fetch.sv
lsu_access.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_mem_subsys -f sim.f -o sim_bin

./obj_dir/sim_bin | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
